/* tb.f */
hdl/soc_bus_pkg.sv
hdl/bus_arbiter.sv
hdl/mem_sram.sv
hdl/uart_tx.sv
hdl/clint_timer.sv
hdl/soc_bus_top.sv
dv/soc_bus_properties.sv
dv/soc_bus_tb.sv

/* Bender.yml */
package:
  name: soc_bus

sources:
  - files:
      - hdl/soc_bus_pkg.sv
      - hdl/bus_arbiter.sv
      - hdl/mem_sram.sv
      - hdl/uart_tx.sv
      - hdl/clint_timer.sv
      - hdl/soc_bus_top.sv
  - target: test
    files:
      - dv/soc_bus_properties.sv
      - dv/soc_bus_tb.sv

/* dv/soc_bus_tb.sv */
`default_nettype none

module soc_bus_tb;
  import soc_bus_pkg::*;

  localparam int unsigned TIMEOUT = 200;
  localparam int unsigned N_OPS   = 400;
  localparam int unsigned N_SLOTS = 32;

  logic              clk = 1'b0;
  logic              reset_i;
  logic [ADDR_W-1:0] ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i;
  logic              ifu_arvalid_i, ifu_rready_i, lsu_arvalid_i, lsu_rready_i;
  logic              lsu_awvalid_i, lsu_wvalid_i, lsu_bready_i;
  logic [DATA_W-1:0] lsu_wdata_i, ifu_rdata_o, lsu_rdata_o;
  logic [STRB_W-1:0] lsu_wstrb_i;
  logic              ifu_arready_o, ifu_rvalid_o, lsu_arready_o, lsu_rvalid_o;
  logic              lsu_awready_o, lsu_wready_o, lsu_bvalid_o, serial_valid_o;
  logic [RESP_W-1:0] ifu_rresp_o, lsu_rresp_o, lsu_bresp_o;
  logic [7:0]        serial_data_o;

  // reference model
  logic [DATA_W-1:0] shadow [SRAM_WORDS];
  logic [7:0]        serial_q [$];
  logic [31:0]       cycle_q;
  logic [31:0]       lcg_state;

  soc_bus_top i_soc_bus_top (.*);

  always #5 clk = ~clk;

  // mtime model that is 0 in the first cycle after reset
  always @(posedge clk) begin
    if (reset_i) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 32'd1;
    end
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    // serial bytes must come out in store order
    if (!reset_i && serial_valid_o) begin
      if (serial_q.size() == 0) begin
        stop_run("serial port emitted a byte that no store asked for");
      end else begin
        check_value("serial_data_o", serial_data_o, serial_q.pop_front());
      end
    end
    // fetch never jumps a pending load
    if (ifu_arready_o && lsu_arvalid_i) begin
      stop_run("ifu read was accepted while an lsu load was waiting");
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {16'h0, lcg_state[31:16]};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    hi = next_rand();
    return (hi << 16) | next_rand();
  endfunction

  // sram word with the same word index as another address
  function automatic logic [ADDR_W-1:0] alias_addr(input logic [ADDR_W-1:0] addr);
    return SRAM_BASE + ADDR_W'({addr[SRAM_IDX_W+1:2], 2'b00});
  endfunction

  // words spread over the array plus the words that io and unmapped stores alias
  function automatic logic [ADDR_W-1:0] slot_addr(input int unsigned k);
    case (k)
      N_SLOTS - 1: return alias_addr(SERIAL_ADDR);
      N_SLOTS - 2: return alias_addr(MTIME_LO_ADDR);
      N_SLOTS - 3: return alias_addr(32'hA000_0044);
      N_SLOTS - 4: return alias_addr(32'h7FFF_FFFC);
      default: return SRAM_BASE + 32'(k * 33 * 4);
    endcase
  endfunction

  function automatic logic is_sram(input logic [ADDR_W-1:0] addr);
    return (addr >= SRAM_BASE) && (addr < SRAM_BASE + ADDR_W'(4 * SRAM_WORDS));
  endfunction

  function automatic logic [ADDR_W-1:0] hole_addr();
    case (next_rand() % 4)
      0: return 32'h0000_1000;
      1: return SRAM_BASE + 32'h1000;
      2: return 32'hA000_0044;
      default: return 32'h7FFF_FFFC;
    endcase
  endfunction

  // serial port reads and timer stores land on the decode error path
  function automatic logic [ADDR_W-1:0] read_addr();
    logic [31:0] pick;
    pick = next_rand() % 8;
    if (pick < 5) return slot_addr(next_rand() % N_SLOTS);
    if (pick == 5) return MTIME_LO_ADDR;
    if (pick == 6) return (next_rand() % 2) ? MTIME_HI_ADDR : SERIAL_ADDR;
    return hole_addr();
  endfunction

  function automatic logic [ADDR_W-1:0] store_addr();
    logic [31:0] pick;
    pick = next_rand() % 8;
    if (pick < 5) return slot_addr(next_rand() % N_SLOTS);
    if (pick < 7) return SERIAL_ADDR;
    return (next_rand() % 2) ? MTIME_LO_ADDR : hole_addr();
  endfunction

  task automatic set_ready(input int port, input logic v);
    case (port)
      0: ifu_rready_i <= v;
      1: lsu_rready_i <= v;
      default: lsu_bready_i <= v;
    endcase
  endtask

  // port 0 is ifu, 1 is lsu load, 2 is lsu store
  task automatic wait_accept(input int port, output logic [31:0] acc_cyc);
    int unsigned n;
    logic        rdy;
    n = 0;
    rdy = 1'b0;
    while (!rdy) begin
      @(posedge clk);
      n++;
      case (port)
        0: rdy = ifu_arready_o;
        1: rdy = lsu_arready_o;
        default: rdy = lsu_awready_o && lsu_wready_o;
      endcase
      if (!rdy && n >= TIMEOUT) begin
        stop_run("timeout: a request was never accepted");
      end
    end
    acc_cyc = cycle_q;
    case (port)
      0: ifu_arvalid_i <= 1'b0;
      1: lsu_arvalid_i <= 1'b0;
      default: begin
        lsu_awvalid_i <= 1'b0;
        lsu_wvalid_i  <= 1'b0;
      end
    endcase
  endtask

  // holds ready low for a random number of valid cycles first
  task automatic collect_resp(input int port, input logic [31:0] exp_d,
                              input logic [RESP_W-1:0] exp_r);
    int unsigned       n, hold;
    logic              vld, rdy, seen, done;
    logic [31:0]       d, first_d;
    logic [RESP_W-1:0] r, first_r;
    string             dname, rname;
    n = 0;
    seen = 1'b0;
    done = 1'b0;
    dname = (port == 0) ? "ifu_rdata_o" : "lsu_rdata_o";
    rname = (port == 0) ? "ifu_rresp_o" : ((port == 1) ? "lsu_rresp_o" : "lsu_bresp_o");
    hold = next_rand() % 4;
    set_ready(port, hold == 0);
    while (!done) begin
      @(posedge clk);
      n++;
      vld = (port == 0) ? ifu_rvalid_o : ((port == 1) ? lsu_rvalid_o : lsu_bvalid_o);
      rdy = (port == 0) ? ifu_rready_i : ((port == 1) ? lsu_rready_i : lsu_bready_i);
      d   = (port == 0) ? ifu_rdata_o : lsu_rdata_o;
      r   = (port == 0) ? ifu_rresp_o : ((port == 1) ? lsu_rresp_o : lsu_bresp_o);
      if (vld) begin
        if (seen && port != 2) begin
          check_value(dname, d, first_d);
        end
        if (seen) begin
          check_value(rname, r, first_r);
        end
        seen = 1'b1;
        first_d = d;
        first_r = r;
        if (rdy) begin
          done = 1'b1;
        end else begin
          if (hold > 0) hold--;
          if (hold == 0) set_ready(port, 1'b1);
        end
      end
      if (!done && n >= TIMEOUT) begin
        stop_run("timeout: a response never completed its handshake");
      end
    end
    set_ready(port, 1'b0);
    if (port != 2) begin
      check_value(dname, d, exp_d);
    end
    check_value(rname, r, exp_r);
  endtask

  task automatic issue_read(input int port, input logic [ADDR_W-1:0] addr);
    if (port == 0) begin
      ifu_araddr_i  <= addr;
      ifu_arvalid_i <= 1'b1;
    end else begin
      lsu_araddr_i  <= addr;
      lsu_arvalid_i <= 1'b1;
    end
  endtask

  task automatic finish_read(input int port, input logic [ADDR_W-1:0] addr);
    logic [31:0]       acc_cyc, exp_d;
    logic [RESP_W-1:0] exp_r;
    wait_accept(port, acc_cyc);
    exp_r = RESP_OKAY;
    if (is_sram(addr)) begin
      exp_d = shadow[addr[SRAM_IDX_W+1:2]];
    end else if (addr == MTIME_LO_ADDR) begin
      exp_d = acc_cyc;
    end else if (addr == MTIME_HI_ADDR) begin
      // upper word stays 0 over a short run
      exp_d = '0;
    end else begin
      exp_d = '0;
      exp_r = RESP_DECERR;
    end
    collect_resp(port, exp_d, exp_r);
  endtask

  task automatic do_store(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                          input logic [STRB_W-1:0] strb);
    logic [31:0]       acc_cyc;
    logic [RESP_W-1:0] exp_r;
    lsu_awaddr_i  <= addr;
    lsu_wdata_i   <= data;
    lsu_wstrb_i   <= strb;
    lsu_awvalid_i <= 1'b1;
    lsu_wvalid_i  <= 1'b1;
    exp_r = RESP_OKAY;
    if (is_sram(addr)) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb[b]) shadow[addr[SRAM_IDX_W+1:2]][8*b +: 8] = data[8*b +: 8];
      end
    end else if (addr == SERIAL_ADDR) begin
      serial_q.push_back(data[7:0]);
    end else begin
      exp_r = RESP_DECERR;
    end
    wait_accept(2, acc_cyc);
    collect_resp(2, '0, exp_r);
  endtask

  task automatic random_op();
    logic [31:0]       sel;
    logic [ADDR_W-1:0] a0, a1;
    sel = next_rand() % 8;
    a0 = read_addr();
    a1 = read_addr();
    if (sel < 3) begin
      issue_read(1, a0);
      finish_read(1, a0);
    end else if (sel < 5) begin
      issue_read(0, a0);
      finish_read(0, a0);
    end else if (sel < 7) begin
      do_store(store_addr(), rand_word(), STRB_W'(next_rand() % 16));
    end else begin
      // load goes first when both are raised together
      issue_read(0, a0);
      issue_read(1, a1);
      finish_read(1, a1);
      finish_read(0, a0);
    end
    repeat (next_rand() % 3) @(posedge clk);
  endtask

  initial begin
    lcg_state = 32'd37;
    reset_i       <= 1'b1;
    ifu_araddr_i  <= '0;
    ifu_arvalid_i <= 1'b0;
    ifu_rready_i  <= 1'b0;
    lsu_araddr_i  <= '0;
    lsu_arvalid_i <= 1'b0;
    lsu_rready_i  <= 1'b0;
    lsu_awaddr_i  <= '0;
    lsu_awvalid_i <= 1'b0;
    lsu_wdata_i   <= '0;
    lsu_wstrb_i   <= '0;
    lsu_wvalid_i  <= 1'b0;
    lsu_bready_i  <= 1'b0;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    @(posedge clk);
    check_value("ifu_arready_o ifu_rvalid_o lsu_arready_o lsu_rvalid_o",
                {ifu_arready_o, ifu_rvalid_o, lsu_arready_o, lsu_rvalid_o}, '0);
    check_value("lsu_awready_o lsu_wready_o lsu_bvalid_o serial_valid_o",
                {lsu_awready_o, lsu_wready_o, lsu_bvalid_o, serial_valid_o}, '0);
    // give every word in use a known value
    for (int k = 0; k < N_SLOTS; k++) begin
      do_store(slot_addr(k), rand_word(), 4'hF);
    end
    for (int i = 0; i < N_OPS; i++) begin
      random_op();
    end
    repeat (3) @(posedge clk);
    if (serial_q.size() != 0) begin
      stop_run("serial port never emitted some of the stored bytes");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/soc_bus_properties.sv */
`default_nettype none

module soc_bus_properties (
  input logic clk,
  input logic reset_i,
  input logic ifu_rvalid_i,
  input logic ifu_rready_i,
  input logic lsu_rvalid_i,
  input logic lsu_rready_i,
  input logic lsu_bvalid_i,
  input logic lsu_bready_i,
  input logic sram_rd_i,
  input logic clint_rd_i,
  input logic uart_wr_i
);

  // responses wait for the owner
  ifu_rvalid_hold: assert property (@(posedge clk) disable iff (reset_i)
    ifu_rvalid_i && !ifu_rready_i |=> ifu_rvalid_i)
    else $error("ifu_rvalid_o dropped before its handshake");
  lsu_rvalid_hold: assert property (@(posedge clk) disable iff (reset_i)
    lsu_rvalid_i && !lsu_rready_i |=> lsu_rvalid_i)
    else $error("lsu_rvalid_o dropped before its handshake");
  lsu_bvalid_hold: assert property (@(posedge clk) disable iff (reset_i)
    lsu_bvalid_i && !lsu_bready_i |=> lsu_bvalid_i)
    else $error("lsu_bvalid_o dropped before its handshake");

  one_reader: assert property (@(posedge clk) disable iff (reset_i)
    !(ifu_rvalid_i && lsu_rvalid_i))
    else $error("ifu and lsu read responses valid together");
  one_target: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({sram_rd_i, clint_rd_i, uart_wr_i}))
    else $error("more than one target requested in one cycle");

endmodule

bind bus_arbiter soc_bus_properties i_soc_bus_properties (
  .clk(clk), .reset_i(reset_i),
  .ifu_rvalid_i(ifu_rvalid_o), .ifu_rready_i(ifu_rready_i),
  .lsu_rvalid_i(lsu_rvalid_o), .lsu_rready_i(lsu_rready_i),
  .lsu_bvalid_i(lsu_bvalid_o), .lsu_bready_i(lsu_bready_i),
  .sram_rd_i(sram_rd_o), .clint_rd_i(clint_rd_o), .uart_wr_i(uart_wr_o)
);

`default_nettype wire

/* hdl/soc_bus_top.sv */
`default_nettype none

module soc_bus_top (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic [soc_bus_pkg::ADDR_W-1:0]  ifu_araddr_i,
  input  logic                            ifu_arvalid_i,
  output logic                            ifu_arready_o,
  output logic [soc_bus_pkg::DATA_W-1:0]  ifu_rdata_o,
  output logic [soc_bus_pkg::RESP_W-1:0]  ifu_rresp_o,
  output logic                            ifu_rvalid_o,
  input  logic                            ifu_rready_i,
  input  logic [soc_bus_pkg::ADDR_W-1:0]  lsu_araddr_i,
  input  logic                            lsu_arvalid_i,
  output logic                            lsu_arready_o,
  output logic [soc_bus_pkg::DATA_W-1:0]  lsu_rdata_o,
  output logic [soc_bus_pkg::RESP_W-1:0]  lsu_rresp_o,
  output logic                            lsu_rvalid_o,
  input  logic                            lsu_rready_i,
  input  logic [soc_bus_pkg::ADDR_W-1:0]  lsu_awaddr_i,
  input  logic                            lsu_awvalid_i,
  output logic                            lsu_awready_o,
  input  logic [soc_bus_pkg::DATA_W-1:0]  lsu_wdata_i,
  input  logic [soc_bus_pkg::STRB_W-1:0]  lsu_wstrb_i,
  input  logic                            lsu_wvalid_i,
  output logic                            lsu_wready_o,
  output logic [soc_bus_pkg::RESP_W-1:0]  lsu_bresp_o,
  output logic                            lsu_bvalid_o,
  input  logic                            lsu_bready_i,
  output logic [7:0]                      serial_data_o,
  output logic                            serial_valid_o
);
  import soc_bus_pkg::*;

  logic              sram_rd, sram_wr, sram_rready, sram_bready, sram_rvalid, sram_bvalid;
  logic [ADDR_W-1:0] sram_addr;
  logic [DATA_W-1:0] sram_wdata, sram_rdata, clint_rdata;
  logic [STRB_W-1:0] sram_wstrb;
  logic              uart_wr, uart_bvalid, uart_bready;
  logic [7:0]        uart_byte;
  logic              clint_rd, clint_hi, clint_rvalid, clint_rready;

  // requester ports share their names with the top level
  bus_arbiter i_bus_arbiter (
    .*,
    .sram_rd_o(sram_rd), .sram_wr_o(sram_wr), .sram_addr_o(sram_addr),
    .sram_wdata_o(sram_wdata), .sram_wstrb_o(sram_wstrb),
    .sram_rready_o(sram_rready), .sram_bready_o(sram_bready),
    .sram_rvalid_i(sram_rvalid), .sram_rdata_i(sram_rdata), .sram_bvalid_i(sram_bvalid),
    .uart_wr_o(uart_wr), .uart_byte_o(uart_byte),
    .uart_bvalid_i(uart_bvalid), .uart_bready_o(uart_bready),
    .clint_rd_o(clint_rd), .clint_hi_o(clint_hi), .clint_rvalid_i(clint_rvalid),
    .clint_rdata_i(clint_rdata), .clint_rready_o(clint_rready)
  );

  mem_sram i_mem_sram (
    .clk(clk), .reset_i(reset_i),
    .rd_i(sram_rd), .wr_i(sram_wr), .addr_i(sram_addr),
    .wdata_i(sram_wdata), .wstrb_i(sram_wstrb),
    .rvalid_o(sram_rvalid), .rdata_o(sram_rdata), .rready_i(sram_rready),
    .bvalid_o(sram_bvalid), .bready_i(sram_bready)
  );

  uart_tx i_uart_tx (
    .clk(clk), .reset_i(reset_i),
    .wr_i(uart_wr), .byte_i(uart_byte),
    .bvalid_o(uart_bvalid), .bready_i(uart_bready),
    .serial_data_o(serial_data_o), .serial_valid_o(serial_valid_o)
  );

  clint_timer i_clint_timer (
    .clk(clk), .reset_i(reset_i),
    .rd_i(clint_rd), .hi_i(clint_hi),
    .rvalid_o(clint_rvalid), .rdata_o(clint_rdata), .rready_i(clint_rready)
  );

endmodule

`default_nettype wire

/* hdl/clint_timer.sv */
`default_nettype none

module clint_timer (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic                            rd_i,
  input  logic                            hi_i,
  output logic                            rvalid_o,
  output logic [soc_bus_pkg::DATA_W-1:0]  rdata_o,
  input  logic                            rready_i
);
  import soc_bus_pkg::*;

  logic [2*DATA_W-1:0] mtime_q;
  logic [DATA_W-1:0]   rdata_q;
  logic                rvalid_q;

  // mtime counts every cycle, zero right after reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_i) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // snapshot of the selected word at the accept
  always_ff @(posedge clk) begin
    if (rd_i) begin
      rdata_q <= hi_i ? mtime_q[2*DATA_W-1:DATA_W] : mtime_q[DATA_W-1:0];
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       wr_i,
  input  logic [7:0] byte_i,
  output logic       bvalid_o,
  input  logic       bready_i,
  output logic [7:0] serial_data_o,
  output logic       serial_valid_o
);

  logic [7:0] data_q;
  logic       strobe_q;
  logic       bvalid_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      strobe_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      // one pulse per accepted store
      strobe_q <= wr_i;
      if (wr_i) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_i) begin
      data_q <= byte_i;
    end
  end

  assign serial_data_o  = data_q;
  assign serial_valid_o = strobe_q;
  assign bvalid_o       = bvalid_q;

endmodule

`default_nettype wire

/* hdl/mem_sram.sv */
`default_nettype none

module mem_sram (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic                            rd_i,
  input  logic                            wr_i,
  input  logic [soc_bus_pkg::ADDR_W-1:0]  addr_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]  wdata_i,
  input  logic [soc_bus_pkg::STRB_W-1:0]  wstrb_i,
  output logic                            rvalid_o,
  output logic [soc_bus_pkg::DATA_W-1:0]  rdata_o,
  input  logic                            rready_i,
  output logic                            bvalid_o,
  input  logic                            bready_i
);
  import soc_bus_pkg::*;

  logic [DATA_W-1:0]     mem_q [SRAM_WORDS];
  logic [SRAM_IDX_W-1:0] idx, rd_idx_q;
  logic [19:0]           lfsr_q;
  logic [1:0]            cnt_q;
  logic                  wait_q, rvalid_q, bvalid_q, load_now;
  logic [DATA_W-1:0]     rdata_q;

  assign idx = addr_i[SRAM_IDX_W+1:2];

  // data lands either right at the accept or when the delay runs out
  assign load_now = (rd_i && (lfsr_q[1:0] == 2'd0)) || (wait_q && (cnt_q == 2'd1));

  // x^20 + x^17 + 1, free running
  always_ff @(posedge clk) begin
    if (reset_i) begin
      lfsr_q <= 20'hACE1;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      cnt_q    <= 2'd0;
      wait_q   <= 1'b0;
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (rd_i) begin
        cnt_q  <= lfsr_q[1:0];
        wait_q <= (lfsr_q[1:0] != 2'd0);
      end else if (wait_q) begin
        cnt_q <= cnt_q - 2'd1;
        if (cnt_q == 2'd1) begin
          wait_q <= 1'b0;
        end
      end
      if (load_now) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
      if (wr_i) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // array and read data
  always_ff @(posedge clk) begin
    if (rd_i) begin
      rd_idx_q <= idx;
    end
    if (load_now) begin
      rdata_q <= mem_q[wait_q ? rd_idx_q : idx];
    end
    if (wr_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign bvalid_o = bvalid_q;

endmodule

`default_nettype wire

/* hdl/bus_arbiter.sv */
`default_nettype none

module bus_arbiter (
  input  logic                              clk,
  input  logic                              reset_i,
  // ifu fetch
  input  logic [soc_bus_pkg::ADDR_W-1:0]    ifu_araddr_i,
  input  logic                              ifu_arvalid_i,
  output logic                              ifu_arready_o,
  output logic [soc_bus_pkg::DATA_W-1:0]    ifu_rdata_o,
  output logic [soc_bus_pkg::RESP_W-1:0]    ifu_rresp_o,
  output logic                              ifu_rvalid_o,
  input  logic                              ifu_rready_i,
  // lsu load
  input  logic [soc_bus_pkg::ADDR_W-1:0]    lsu_araddr_i,
  input  logic                              lsu_arvalid_i,
  output logic                              lsu_arready_o,
  output logic [soc_bus_pkg::DATA_W-1:0]    lsu_rdata_o,
  output logic [soc_bus_pkg::RESP_W-1:0]    lsu_rresp_o,
  output logic                              lsu_rvalid_o,
  input  logic                              lsu_rready_i,
  // lsu store
  input  logic [soc_bus_pkg::ADDR_W-1:0]    lsu_awaddr_i,
  input  logic                              lsu_awvalid_i,
  output logic                              lsu_awready_o,
  input  logic [soc_bus_pkg::DATA_W-1:0]    lsu_wdata_i,
  input  logic [soc_bus_pkg::STRB_W-1:0]    lsu_wstrb_i,
  input  logic                              lsu_wvalid_i,
  output logic                              lsu_wready_o,
  output logic [soc_bus_pkg::RESP_W-1:0]    lsu_bresp_o,
  output logic                              lsu_bvalid_o,
  input  logic                              lsu_bready_i,
  // data sram
  output logic                              sram_rd_o,
  output logic                              sram_wr_o,
  output logic [soc_bus_pkg::ADDR_W-1:0]    sram_addr_o,
  output logic [soc_bus_pkg::DATA_W-1:0]    sram_wdata_o,
  output logic [soc_bus_pkg::STRB_W-1:0]    sram_wstrb_o,
  output logic                              sram_rready_o,
  output logic                              sram_bready_o,
  input  logic                              sram_rvalid_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]    sram_rdata_i,
  input  logic                              sram_bvalid_i,
  // serial port
  output logic                              uart_wr_o,
  output logic [7:0]                        uart_byte_o,
  input  logic                              uart_bvalid_i,
  output logic                              uart_bready_o,
  // timer
  output logic                              clint_rd_o,
  output logic                              clint_hi_o,
  input  logic                              clint_rvalid_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]    clint_rdata_i,
  output logic                              clint_rready_o
);
  import soc_bus_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_IFU, ST_LD, ST_ST, ST_ERR} state_e;
  typedef enum logic [1:0] {OWN_IFU, OWN_LD, OWN_ST} owner_e;

  state_e              state_q;
  owner_e              own_q;
  // set when the owner talks to the serial port or the timer
  logic                tgt_io_q;
  logic                idle, st_req, acc_st, acc_ld, acc_if, acc_rd;
  logic [ADDR_W-1:0]   req_addr;
  logic                hit_sram, hit_uart, hit_lo, hit_hi, hit_timer, dec_err;
  logic                rd_rsp_valid, wr_rsp_valid, rsp_done, cur_rready;
  logic [DATA_W-1:0]   rd_rsp_data;
  logic [RESP_W-1:0]   rsp_code;

  // fixed priority: store, load, fetch
  assign idle   = (state_q == ST_IDLE);
  assign st_req = lsu_awvalid_i && lsu_wvalid_i;
  assign acc_st = idle && st_req;
  assign acc_ld = idle && !st_req && lsu_arvalid_i;
  assign acc_if = idle && !st_req && !lsu_arvalid_i && ifu_arvalid_i;
  assign acc_rd = acc_ld || acc_if;

  assign lsu_awready_o = acc_st;
  assign lsu_wready_o  = acc_st;
  assign lsu_arready_o = acc_ld;
  assign ifu_arready_o = acc_if;

  assign req_addr = st_req ? lsu_awaddr_i : (lsu_arvalid_i ? lsu_araddr_i : ifu_araddr_i);

  // address decode
  assign hit_sram  = (req_addr[ADDR_W-1:SRAM_IDX_W+2] == SRAM_BASE[ADDR_W-1:SRAM_IDX_W+2]);
  assign hit_uart  = (req_addr == SERIAL_ADDR);
  assign hit_lo    = (req_addr == MTIME_LO_ADDR);
  assign hit_hi    = (req_addr == MTIME_HI_ADDR);
  assign hit_timer = hit_lo || hit_hi;
  // timer is read only, serial port is write only
  assign dec_err   = (acc_st && !(hit_sram || hit_uart)) ||
                     (acc_rd && !(hit_sram || hit_timer));

  // request side to targets
  assign sram_rd_o    = acc_rd && hit_sram;
  assign sram_wr_o    = acc_st && hit_sram;
  assign sram_addr_o  = req_addr;
  assign sram_wdata_o = lsu_wdata_i;
  assign sram_wstrb_o = lsu_wstrb_i;
  assign uart_wr_o    = acc_st && hit_uart;
  assign uart_byte_o  = lsu_wdata_i[7:0];
  assign clint_rd_o   = acc_rd && hit_timer;
  assign clint_hi_o   = hit_hi;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q  <= ST_IDLE;
      own_q    <= OWN_IFU;
      tgt_io_q <= 1'b0;
    end else if (idle) begin
      tgt_io_q <= acc_st ? hit_uart : hit_timer;
      if (acc_st) begin
        own_q <= OWN_ST;
      end else if (acc_ld) begin
        own_q <= OWN_LD;
      end else begin
        own_q <= OWN_IFU;
      end
      if (dec_err) begin
        state_q <= ST_ERR;
      end else if (acc_st) begin
        state_q <= ST_ST;
      end else if (acc_ld) begin
        state_q <= ST_LD;
      end else if (acc_if) begin
        state_q <= ST_IFU;
      end
    end else if (rsp_done) begin
      state_q <= ST_IDLE;
    end
  end

  // response side, only the owner sees valid
  assign rd_rsp_valid = tgt_io_q ? clint_rvalid_i : sram_rvalid_i;
  assign wr_rsp_valid = tgt_io_q ? uart_bvalid_i : sram_bvalid_i;
  assign rd_rsp_data  = (state_q == ST_ERR) ? '0 : (tgt_io_q ? clint_rdata_i : sram_rdata_i);
  assign rsp_code     = (state_q == ST_ERR) ? RESP_DECERR : RESP_OKAY;

  assign ifu_rvalid_o = ((state_q == ST_IFU) && rd_rsp_valid) ||
                        ((state_q == ST_ERR) && (own_q == OWN_IFU));
  assign lsu_rvalid_o = ((state_q == ST_LD) && rd_rsp_valid) ||
                        ((state_q == ST_ERR) && (own_q == OWN_LD));
  assign lsu_bvalid_o = ((state_q == ST_ST) && wr_rsp_valid) ||
                        ((state_q == ST_ERR) && (own_q == OWN_ST));
  assign ifu_rdata_o  = rd_rsp_data;
  assign lsu_rdata_o  = rd_rsp_data;
  assign ifu_rresp_o  = rsp_code;
  assign lsu_rresp_o  = rsp_code;
  assign lsu_bresp_o  = rsp_code;

  assign rsp_done = (ifu_rvalid_o && ifu_rready_i) || (lsu_rvalid_o && lsu_rready_i) ||
                    (lsu_bvalid_o && lsu_bready_i);

  // forward the owner's ready to the selected target
  assign cur_rready     = (state_q == ST_IFU) ? ifu_rready_i : lsu_rready_i;
  assign sram_rready_o  = ((state_q == ST_IFU) || (state_q == ST_LD)) && !tgt_io_q && cur_rready;
  assign clint_rready_o = ((state_q == ST_IFU) || (state_q == ST_LD)) && tgt_io_q && cur_rready;
  assign sram_bready_o  = (state_q == ST_ST) && !tgt_io_q && lsu_bready_i;
  assign uart_bready_o  = (state_q == ST_ST) && tgt_io_q && lsu_bready_i;

endmodule

`default_nettype wire

/* hdl/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // data sram window
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
  localparam int unsigned SRAM_WORDS = 1024;
  // word index sits in addr[11:2]
  localparam int unsigned SRAM_IDX_W = 10;

  // serial port, store only
  localparam logic [ADDR_W-1:0] SERIAL_ADDR = 32'hA000_03F8;

  // core-local timer words
  localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'hA000_0048;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = 32'hA000_004C;

  // response codes
  localparam int unsigned RESP_W = 2;
  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;
  localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

endpackage

`default_nettype wire
